// File: build.f
common/manycore_pkg.sv
source/reset_sequencer.sv
wormhole/wh_request_packetizer.sv
wormhole/wh_concentrator.sv
wormhole/wh_test_mem.sv
wormhole/wh_response_collector.sv
source/manycore_mem_harness.sv
test/tb_manycore_mem_harness.sv

// File: test/tb_manycore_mem_harness.sv
// testbench for the manycore memory harness
// clock, reset, host request stimulus, reference memory model
// and a response checker matched by tag

`timescale 1ns/1ps

module tb_manycore_mem_harness
  import manycore_pkg::*;
  ();

  localparam int NUM_LINKS    = 4;
  localparam int TAG_CYCLES   = 16;
  localparam int RESET_DEPTH  = 3;
  localparam int QUEUE_DEPTH  = 4;
  localparam int RESP_TIMEOUT = 400;

  logic              clk_i = 1'b0;
  logic              rst_i;
  logic              req_v_i;
  logic              req_write_i;
  logic [ADDR_W-1:0] req_addr_i;
  logic [TAG_W-1:0]  req_tag_i;
  logic [DATA_W-1:0] req_data_i;
  logic              tag_done_o;
  logic              overflow_o;
  logic              resp_v_o;
  logic [TAG_W-1:0]  resp_tag_o;
  logic [DATA_W-1:0] resp_data_o;

  // reference memory and outstanding reads
  logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];
  logic [TAG_W-1:0]  pend_tag [$];
  logic [DATA_W-1:0] pend_data [$];
  logic [ADDR_W-1:0] written [$];
  logic [TAG_W-1:0]  tag_ctr;
  logic [31:0]       rng;
  int                reads_issued;
  int                resp_count;
  string             cur_test;

  always #4 clk_i = ~clk_i;

  manycore_mem_harness #(
    .NUM_LINKS(NUM_LINKS)
    ,.TAG_CYCLES(TAG_CYCLES)
    ,.RESET_DEPTH(RESET_DEPTH)
    ,.QUEUE_DEPTH(QUEUE_DEPTH)
  ) manycore_mem_harness_inst (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.req_v_i(req_v_i)
    ,.req_write_i(req_write_i)
    ,.req_addr_i(req_addr_i)
    ,.req_tag_i(req_tag_i)
    ,.req_data_i(req_data_i)
    ,.tag_done_o(tag_done_o)
    ,.overflow_o(overflow_o)
    ,.resp_v_o(resp_v_o)
    ,.resp_tag_o(resp_tag_o)
    ,.resp_data_o(resp_data_o)
  );

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // a read returns the last word written to its address
  function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
    if (ref_mem.exists(addr)) begin
      return ref_mem[addr];
    end
    return '0;
  endfunction

  task automatic fail_with(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      fail_with($sformatf("mismatch %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // one strobe, then three idle cycles
  task automatic issue_request(input logic write, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data);
    if (write) begin
      ref_mem[addr] = data;
    end else begin
      pend_tag.push_back(tag_ctr);
      pend_data.push_back(expected_read(addr));
      reads_issued++;
    end
    @(posedge clk_i);
    #1;
    req_v_i     = 1'b1;
    req_write_i = write;
    req_addr_i  = addr;
    req_tag_i   = tag_ctr;
    req_data_i  = data;
    @(posedge clk_i);
    #1;
    req_v_i = 1'b0;
    repeat (2) @(posedge clk_i);
    tag_ctr = tag_ctr + 1'b1;
  endtask

  task automatic wait_responses(input string what);
    int waited;
    waited = 0;
    while (resp_count != reads_issued) begin
      if (waited == RESP_TIMEOUT) begin
        fail_with($sformatf("timed out waiting for read responses in %s", what));
      end
      @(posedge clk_i);
      waited++;
    end
  endtask

  // --------------------------------------------------------------------------
  // response checker
  // --------------------------------------------------------------------------

  always @(negedge clk_i) begin : compare_responses
    int idx;
    if (rst_i === 1'b0) begin
      if (overflow_o) begin
        fail_with("overflow_o went high, a request queue was full");
      end
      if (resp_v_o) begin
        idx = -1;
        for (int i = 0; i < pend_tag.size(); i++) begin
          if (idx < 0 && pend_tag[i] == resp_tag_o) idx = i;
        end
        if (idx < 0) begin
          fail_with($sformatf("response with tag %0h matches no outstanding read",
                              resp_tag_o));
        end
        check_value({cur_test, " read data"}, pend_data[idx], resp_data_o);
        pend_tag.delete(idx);
        pend_data.delete(idx);
        resp_count++;
      end
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  initial begin : stimulus
    int                cycles;
    logic [ADDR_W-1:0] addr;
    rst_i        = 1'b1;
    req_v_i      = 1'b0;
    req_write_i  = 1'b0;
    req_addr_i   = '0;
    req_tag_i    = '0;
    req_data_i   = '0;
    tag_ctr      = '0;
    rng          = 32'd24;
    reads_issued = 0;
    resp_count   = 0;
    cur_test     = "reset sequence";

    repeat (5) begin
      @(posedge clk_i);
      #1;
      check_value("reset tag_done_o", 0, tag_done_o);
      check_value("reset resp_v_o", 0, resp_v_o);
      check_value("reset overflow_o", 0, overflow_o);
    end
    rst_i = 1'b0;

    // count edges after the first one with reset low
    cycles = 0;
    @(posedge clk_i);
    #1;
    while (!tag_done_o) begin
      if (cycles > TAG_CYCLES + 8) fail_with("timed out waiting for tag_done_o to rise");
      @(posedge clk_i);
      #1;
      cycles++;
    end
    check_value("tag phase length", TAG_CYCLES, cycles);
    repeat (RESET_DEPTH) @(posedge clk_i);

    cur_test = "single link";
    for (int i = 0; i < 4; i++) begin
      rng = xorshift32(rng);
      written.push_back(ADDR_W'((rng >> 4) * NUM_LINKS + 1));
      issue_request(1'b1, written[i], xorshift32(rng ^ 32'h5a5a));
    end
    for (int i = 0; i < 4; i++) begin
      issue_request(1'b0, written[i], '0);
    end
    wait_responses(cur_test);

    cur_test = "all links";
    for (int i = 0; i < 2 * NUM_LINKS; i++) begin
      rng = xorshift32(rng);
      addr = ADDR_W'((rng >> 8) * NUM_LINKS + i % NUM_LINKS);
      rng = xorshift32(rng);
      written.push_back(addr);
      issue_request(1'b1, addr, rng);
    end
    for (int i = 0; i < 24; i++) begin
      rng = xorshift32(rng);
      if (rng[0]) begin
        issue_request(1'b0, written[rng[15:8] % written.size()], '0);
      end else begin
        addr = ADDR_W'(rng >> 16);
        written.push_back(addr);
        rng = xorshift32(rng);
        issue_request(1'b1, addr, rng);
      end
    end
    wait_responses(cur_test);

    cur_test = "overwrite ordering";
    rng = xorshift32(rng);
    addr = ADDR_W'(rng >> 3);
    issue_request(1'b1, addr, 32'h1111_0000 ^ rng);
    issue_request(1'b1, addr, 32'h2222_0000 ^ rng);
    issue_request(1'b0, addr, '0);
    wait_responses(cur_test);

    cur_test = "write count";
    for (int i = 0; i < 6; i++) begin
      rng = xorshift32(rng);
      issue_request(1'b1, ADDR_W'(rng >> 12), xorshift32(rng));
    end
    repeat (30) @(posedge clk_i);
    check_value("write count total reads", reads_issued, resp_count);

    $display("Simulation passed");
    $finish;
  end

endmodule

// File: source/manycore_mem_harness.sv
// top level of the memory harness
// sequencer, request endpoints, wormhole concentrator,
// test memory and response collector

`timescale 1ns/1ps

module manycore_mem_harness
  import manycore_pkg::*;
  #(parameter int NUM_LINKS = 4
    , parameter int TAG_CYCLES = 16
    , parameter int RESET_DEPTH = 3
    , parameter int QUEUE_DEPTH = 4
  )
  (
    input  logic              clk_i
    , input  logic              rst_i

    , input  logic              req_v_i
    , input  logic              req_write_i
    , input  logic [ADDR_W-1:0] req_addr_i
    , input  logic [TAG_W-1:0]  req_tag_i
    , input  logic [DATA_W-1:0] req_data_i

    , output logic              tag_done_o
    , output logic              overflow_o
    , output logic              resp_v_o
    , output logic [TAG_W-1:0]  resp_tag_o
    , output logic [DATA_W-1:0] resp_data_o
  );

  logic core_rst_lo;

  // endpoint request links
  logic [NUM_LINKS*DATA_W-1:0] req_flit_lo;
  logic [NUM_LINKS-1:0]        req_v_lo;
  logic [NUM_LINKS-1:0]        req_ready_li;

  // concentrated pair toward the memory
  logic [DATA_W-1:0] conc_flit_lo;
  logic              conc_v_lo;
  logic              conc_ready_li;
  logic [DATA_W-1:0] mem_ret_flit_lo;
  logic              mem_ret_v_lo;
  logic              mem_ret_ready_li;

  // endpoint return links
  logic [NUM_LINKS*DATA_W-1:0] ret_flit_lo;
  logic [NUM_LINKS-1:0]        ret_v_lo;
  logic [NUM_LINKS-1:0]        ret_ready_li;

  reset_sequencer #(
    .TAG_CYCLES(TAG_CYCLES)
    ,.RESET_DEPTH(RESET_DEPTH)
  ) reset_sequencer_inst (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.tag_done_o(tag_done_o)
    ,.core_rst_o(core_rst_lo)
  );

  wh_request_packetizer #(
    .NUM_LINKS(NUM_LINKS)
    ,.QUEUE_DEPTH(QUEUE_DEPTH)
  ) wh_request_packetizer_inst (
    .clk_i(clk_i)
    ,.rst_i(core_rst_lo)
    ,.req_v_i(req_v_i)
    ,.req_write_i(req_write_i)
    ,.req_addr_i(req_addr_i)
    ,.req_tag_i(req_tag_i)
    ,.req_data_i(req_data_i)
    ,.link_ready_i(req_ready_li)
    ,.link_flit_o(req_flit_lo)
    ,.link_v_o(req_v_lo)
    ,.overflow_o(overflow_o)
  );

  wh_concentrator #(
    .NUM_LINKS(NUM_LINKS)
  ) wh_concentrator_inst (
    .clk_i(clk_i)
    ,.rst_i(core_rst_lo)
    ,.in_flit_i(req_flit_lo)
    ,.in_v_i(req_v_lo)
    ,.in_ready_o(req_ready_li)
    ,.conc_flit_o(conc_flit_lo)
    ,.conc_v_o(conc_v_lo)
    ,.conc_ready_i(conc_ready_li)
    ,.conc_ret_flit_i(mem_ret_flit_lo)
    ,.conc_ret_v_i(mem_ret_v_lo)
    ,.conc_ret_ready_o(mem_ret_ready_li)
    ,.ret_flit_o(ret_flit_lo)
    ,.ret_v_o(ret_v_lo)
    ,.ret_ready_i(ret_ready_li)
  );

  wh_test_mem wh_test_mem_inst (
    .clk_i(clk_i)
    ,.rst_i(core_rst_lo)
    ,.flit_i(conc_flit_lo)
    ,.v_i(conc_v_lo)
    ,.ready_o(conc_ready_li)
    ,.ret_flit_o(mem_ret_flit_lo)
    ,.ret_v_o(mem_ret_v_lo)
    ,.ret_ready_i(mem_ret_ready_li)
  );

  wh_response_collector #(
    .NUM_LINKS(NUM_LINKS)
  ) wh_response_collector_inst (
    .clk_i(clk_i)
    ,.rst_i(core_rst_lo)
    ,.ret_flit_i(ret_flit_lo)
    ,.ret_v_i(ret_v_lo)
    ,.ret_ready_o(ret_ready_li)
    ,.resp_v_o(resp_v_o)
    ,.resp_tag_o(resp_tag_o)
    ,.resp_data_o(resp_data_o)
  );

endmodule

// File: wormhole/wh_response_collector.sv
// gathers read replies from all return links
// one response strobe per reply, lowest link served first

`timescale 1ns/1ps

module wh_response_collector
  import manycore_pkg::*;
  #(parameter int NUM_LINKS = 4
  )
  (
    input  logic                        clk_i
    , input  logic                        rst_i
    , input  logic [NUM_LINKS*DATA_W-1:0] ret_flit_i
    , input  logic [NUM_LINKS-1:0]        ret_v_i
    , output logic [NUM_LINKS-1:0]        ret_ready_o
    , output logic                        resp_v_o
    , output logic [TAG_W-1:0]            resp_tag_o
    , output logic [DATA_W-1:0]           resp_data_o
  );

  logic              busy_q;
  logic [CID_W-1:0]  sel_q;
  logic [LEN_W-1:0]  cnt_q;
  logic [TAG_W-1:0]  tag_q;
  logic [CID_W-1:0]  pick;
  logic [CID_W-1:0]  sel;
  logic [DATA_W-1:0] flit;
  logic              xfer;
  logic              resp_v_q;
  logic [TAG_W-1:0]  resp_tag_q;
  logic [DATA_W-1:0] resp_data_q;

  // lowest valid link wins
  always_comb begin
    pick = '0;
    for (int i = NUM_LINKS - 1; i >= 0; i--) begin
      if (ret_v_i[i]) pick = CID_W'(i);
    end
  end

  assign sel  = busy_q ? sel_q : pick;
  assign flit = ret_flit_i[sel*DATA_W +: DATA_W];
  assign xfer = ret_v_i[sel];

  always_comb begin
    ret_ready_o = '0;
    ret_ready_o[sel] = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q   <= 1'b0;
      sel_q    <= '0;
      cnt_q    <= '0;
      resp_v_q <= 1'b0;
    end else begin
      resp_v_q <= 1'b0;
      if (xfer && !busy_q) begin
        busy_q <= 1'b1;
        sel_q  <= pick;
        cnt_q  <= flit[HDR_LEN_LSB +: LEN_W];
      end else if (xfer) begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == LEN_W'(1)) begin
          busy_q   <= 1'b0;
          resp_v_q <= 1'b1;
        end
      end
    end
  end

  // header gives the tag, last flit the data
  always_ff @(posedge clk_i) begin
    if (xfer && !busy_q) begin
      tag_q <= flit[HDR_TAG_LSB +: TAG_W];
    end
    if (xfer && busy_q && cnt_q == LEN_W'(1)) begin
      resp_tag_q  <= tag_q;
      resp_data_q <= flit;
    end
  end

  assign resp_v_o    = resp_v_q;
  assign resp_tag_o  = resp_tag_q;
  assign resp_data_o = resp_data_q;

endmodule

// File: wormhole/wh_test_mem.sv
// word memory behind the concentrated wormhole link
// writes are silent, reads answer with header plus data

`timescale 1ns/1ps

module wh_test_mem
  import manycore_pkg::*;
  (
    input  logic              clk_i
    , input  logic              rst_i
    , input  logic [DATA_W-1:0] flit_i
    , input  logic              v_i
    , output logic              ready_o
    , output logic [DATA_W-1:0] ret_flit_o
    , output logic              ret_v_o
    , input  logic              ret_ready_i
  );

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_REPLY
  } state_e;

  state_e            state_q;
  wh_op_e            op_q;
  logic [TAG_W-1:0]  tag_q;
  logic [CID_W-1:0]  cid_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] rd_data_q;
  logic              reply_data_q;
  logic [DATA_W-1:0] mem [2**ADDR_W];
  logic [DATA_W-1:0] reply_hdr;
  logic              xfer;
  logic              ret_xfer;

  // no intake while a reply is pending
  assign ready_o  = (state_q != ST_REPLY);
  assign xfer     = v_i && ready_o;
  assign ret_v_o  = (state_q == ST_REPLY);
  assign ret_xfer = ret_v_o && ret_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= ST_IDLE;
      reply_data_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: if (xfer) state_q <= ST_ADDR;
        ST_ADDR: begin
          if (xfer) begin
            reply_data_q <= 1'b0;
            state_q      <= (op_q == WH_OP_WRITE) ? ST_DATA : ST_REPLY;
          end
        end
        ST_DATA: if (xfer) state_q <= ST_IDLE;
        default: begin
          if (ret_xfer) begin
            reply_data_q <= 1'b1;
            if (reply_data_q) state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // request fields, array write and read port
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && xfer) begin
      op_q  <= wh_op_e'(flit_i[HDR_OP_LSB]);
      tag_q <= flit_i[HDR_TAG_LSB +: TAG_W];
      cid_q <= flit_i[HDR_CID_LSB +: CID_W];
    end
    if (state_q == ST_ADDR && xfer) begin
      addr_q    <= flit_i[ADDR_W-1:0];
      rd_data_q <= mem[flit_i[ADDR_W-1:0]];
    end
    if (state_q == ST_DATA && xfer) begin
      mem[addr_q] <= flit_i;
    end
  end

  always_comb begin
    reply_hdr = '0;
    reply_hdr[HDR_OP_LSB] = WH_OP_READ;
    reply_hdr[HDR_TAG_LSB +: TAG_W] = tag_q;
    reply_hdr[HDR_CID_LSB +: CID_W] = cid_q;
    reply_hdr[HDR_LEN_LSB +: LEN_W] = LEN_W'(1);
  end

  assign ret_flit_o = reply_data_q ? rd_data_q : reply_hdr;

endmodule

// File: wormhole/wh_concentrator.sv
// many-to-one wormhole concentrator
// round-robin grant held for a whole packet toward the memory,
// replies routed back to their link by the header cid

`timescale 1ns/1ps

module wh_concentrator
  import manycore_pkg::*;
  #(parameter int NUM_LINKS = 4
  )
  (
    input  logic                        clk_i
    , input  logic                        rst_i
    , input  logic [NUM_LINKS*DATA_W-1:0] in_flit_i
    , input  logic [NUM_LINKS-1:0]        in_v_i
    , output logic [NUM_LINKS-1:0]        in_ready_o
    , output logic [DATA_W-1:0]           conc_flit_o
    , output logic                        conc_v_o
    , input  logic                        conc_ready_i
    , input  logic [DATA_W-1:0]           conc_ret_flit_i
    , input  logic                        conc_ret_v_i
    , output logic                        conc_ret_ready_o
    , output logic [NUM_LINKS*DATA_W-1:0] ret_flit_o
    , output logic [NUM_LINKS-1:0]        ret_v_o
    , input  logic [NUM_LINKS-1:0]        ret_ready_i
  );

  // --------------------------------------------------------------------------
  // forward path
  // --------------------------------------------------------------------------

  logic             fwd_busy_q;
  logic             fwd_hdr_q;
  logic [CID_W-1:0] grant_q;
  logic [CID_W-1:0] last_q;
  logic [LEN_W-1:0] fwd_cnt_q;
  logic [CID_W-1:0] rr_pick;
  logic             rr_found;
  logic             fwd_xfer;

  // search starts one past the last served link
  always_comb begin
    int idx;
    rr_pick  = last_q;
    rr_found = 1'b0;
    for (int k = 1; k <= NUM_LINKS; k++) begin
      idx = (int'(last_q) + k) % NUM_LINKS;
      if (!rr_found && in_v_i[idx]) begin
        rr_pick  = CID_W'(idx);
        rr_found = 1'b1;
      end
    end
  end

  assign conc_v_o    = fwd_busy_q && in_v_i[grant_q];
  assign conc_flit_o = in_flit_i[grant_q*DATA_W +: DATA_W];
  assign fwd_xfer    = conc_v_o && conc_ready_i;

  // only the granted link sees a busy memory
  always_comb begin
    in_ready_o = '0;
    in_ready_o[grant_q] = fwd_busy_q && conc_ready_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fwd_busy_q <= 1'b0;
      fwd_hdr_q  <= 1'b0;
      grant_q    <= '0;
      last_q     <= CID_W'(NUM_LINKS - 1);
      fwd_cnt_q  <= '0;
    end else if (!fwd_busy_q) begin
      if (rr_found) begin
        fwd_busy_q <= 1'b1;
        fwd_hdr_q  <= 1'b1;
        grant_q    <= rr_pick;
      end
    end else if (fwd_xfer) begin
      if (fwd_hdr_q) begin
        fwd_hdr_q <= 1'b0;
        fwd_cnt_q <= conc_flit_o[HDR_LEN_LSB +: LEN_W];
      end else begin
        fwd_cnt_q <= fwd_cnt_q - 1'b1;
        if (fwd_cnt_q == LEN_W'(1)) begin
          fwd_busy_q <= 1'b0;
          last_q     <= grant_q;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // return path
  // --------------------------------------------------------------------------

  logic             ret_busy_q;
  logic [CID_W-1:0] ret_route_q;
  logic [LEN_W-1:0] ret_cnt_q;
  logic [CID_W-1:0] ret_route;
  logic             ret_xfer;

  // header flit names its own route, body flits follow it
  assign ret_route        = ret_busy_q ? ret_route_q : conc_ret_flit_i[HDR_CID_LSB +: CID_W];
  assign conc_ret_ready_o = ret_ready_i[ret_route];
  assign ret_xfer         = conc_ret_v_i && conc_ret_ready_o;
  assign ret_flit_o       = {NUM_LINKS{conc_ret_flit_i}};

  always_comb begin
    for (int i = 0; i < NUM_LINKS; i++) begin
      ret_v_o[i] = conc_ret_v_i && (ret_route == CID_W'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ret_busy_q  <= 1'b0;
      ret_route_q <= '0;
      ret_cnt_q   <= '0;
    end else if (ret_xfer) begin
      if (!ret_busy_q) begin
        ret_busy_q  <= 1'b1;
        ret_route_q <= ret_route;
        ret_cnt_q   <= conc_ret_flit_i[HDR_LEN_LSB +: LEN_W];
      end else begin
        ret_cnt_q <= ret_cnt_q - 1'b1;
        if (ret_cnt_q == LEN_W'(1)) begin
          ret_busy_q <= 1'b0;
        end
      end
    end
  end

endmodule

// File: wormhole/wh_request_packetizer.sv
// per-link request queues fed by host strobes
// each queue emits header, address and, for writes, data flits

`timescale 1ns/1ps

module wh_request_packetizer
  import manycore_pkg::*;
  #(parameter int NUM_LINKS = 4
    , parameter int QUEUE_DEPTH = 4
  )
  (
    input  logic                        clk_i
    , input  logic                        rst_i
    , input  logic                        req_v_i
    , input  logic                        req_write_i
    , input  logic [ADDR_W-1:0]           req_addr_i
    , input  logic [TAG_W-1:0]            req_tag_i
    , input  logic [DATA_W-1:0]           req_data_i
    , input  logic [NUM_LINKS-1:0]        link_ready_i
    , output logic [NUM_LINKS*DATA_W-1:0] link_flit_o
    , output logic [NUM_LINKS-1:0]        link_v_o
    , output logic                        overflow_o
  );

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  logic [CID_W-1:0]     req_link;
  logic [NUM_LINKS-1:0] full;
  logic                 overflow_q;

  // link picked by low address bits, as for cache banks
  assign req_link = CID_W'(req_addr_i % NUM_LINKS);

  for (genvar i = 0; i < NUM_LINKS; i++) begin : link
    wh_op_e            q_op   [QUEUE_DEPTH];
    logic [ADDR_W-1:0] q_addr [QUEUE_DEPTH];
    logic [TAG_W-1:0]  q_tag  [QUEUE_DEPTH];
    logic [DATA_W-1:0] q_data [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic [1:0]        flit_q;
    logic              push;
    logic              pop;
    logic              xfer;
    logic [DATA_W-1:0] hdr;
    logic [DATA_W-1:0] flit;

    assign full[i] = (count_q == CNT_W'(QUEUE_DEPTH));
    assign push    = req_v_i && (req_link == CID_W'(i)) && !full[i];
    assign xfer    = link_v_o[i] && link_ready_i[i];
    assign pop     = xfer && (flit_q == ((q_op[rd_ptr_q] == WH_OP_WRITE) ? 2'd2 : 2'd1));

    always_ff @(posedge clk_i) begin
      if (push) begin
        q_op[wr_ptr_q]   <= req_write_i ? WH_OP_WRITE : WH_OP_READ;
        q_addr[wr_ptr_q] <= req_addr_i;
        q_tag[wr_ptr_q]  <= req_tag_i;
        q_data[wr_ptr_q] <= req_data_i;
      end
    end

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
        flit_q   <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        // header -> address -> data
        if (pop) begin
          flit_q <= '0;
        end else if (xfer) begin
          flit_q <= flit_q + 1'b1;
        end
      end
    end

    always_comb begin
      hdr = '0;
      hdr[HDR_OP_LSB] = q_op[rd_ptr_q];
      hdr[HDR_TAG_LSB +: TAG_W] = q_tag[rd_ptr_q];
      hdr[HDR_CID_LSB +: CID_W] = CID_W'(i);
      hdr[HDR_LEN_LSB +: LEN_W] = (q_op[rd_ptr_q] == WH_OP_WRITE) ? LEN_W'(2) : LEN_W'(1);
      case (flit_q)
        2'd0:    flit = hdr;
        2'd1:    flit = DATA_W'(q_addr[rd_ptr_q]);
        default: flit = q_data[rd_ptr_q];
      endcase
    end

    assign link_flit_o[i*DATA_W +: DATA_W] = flit;
    assign link_v_o[i] = (count_q != '0);
  end

  // sticky until reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      overflow_q <= 1'b0;
    end else if (req_v_i && full[req_link]) begin
      overflow_q <= 1'b1;
    end
  end

  assign overflow_o = overflow_q;

endmodule

// File: source/reset_sequencer.sv
// tag phase counter with done flag
// reset delay chain that releases the core reset

`timescale 1ns/1ps

module reset_sequencer
  #(parameter int TAG_CYCLES = 16
    , parameter int RESET_DEPTH = 3
  )
  (
    input  logic clk_i
    , input  logic rst_i
    , output logic tag_done_o
    , output logic core_rst_o
  );

  localparam int CNT_W = $clog2(TAG_CYCLES + 1);

  logic [CNT_W-1:0]       cnt_q;
  logic                   tag_done_q;
  logic [RESET_DEPTH-1:0] chain_q;

  // tag phase, holds done once reached
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q      <= '0;
      tag_done_q <= 1'b0;
    end else if (!tag_done_q) begin
      if (cnt_q == CNT_W'(TAG_CYCLES)) begin
        tag_done_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // core reset stays high until done has walked the chain
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      chain_q <= '1;
    end else begin
      chain_q[0] <= ~tag_done_q;
      for (int i = 1; i < RESET_DEPTH; i++) begin
        chain_q[i] <= chain_q[i-1];
      end
    end
  end

  assign tag_done_o = tag_done_q;
  // external reset reaches the core at once
  assign core_rst_o = rst_i | chain_q[RESET_DEPTH-1];

endmodule

// File: common/manycore_pkg.sv
// shared widths for the memory side of the manycore harness
// wormhole packet opcodes and header flit field positions

package manycore_pkg;

  // ---------------------------------------------------------------------------
  // widths
  // ---------------------------------------------------------------------------

  // word address into the test memory
  localparam int ADDR_W = 10;

  // data word, also the flit width
  localparam int DATA_W = 32;

  // host request tag
  localparam int TAG_W = 4;

  // concentrator id, names the return link
  localparam int CID_W = 2;

  // flits that follow the header
  localparam int LEN_W = 2;

  // ---------------------------------------------------------------------------
  // packet format
  // ---------------------------------------------------------------------------

  typedef enum logic {
    WH_OP_READ  = 1'b0,
    WH_OP_WRITE = 1'b1
  } wh_op_e;

  // header flit, from lsb up: len, cid, tag, op
  localparam int HDR_LEN_LSB = 0;
  localparam int HDR_CID_LSB = HDR_LEN_LSB + LEN_W;
  localparam int HDR_TAG_LSB = HDR_CID_LSB + CID_W;
  localparam int HDR_OP_LSB  = HDR_TAG_LSB + TAG_W;

endpackage
